/* common/exttime_macros.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// external timestamp logger sizes
// channel count, message length and record length of the logger
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXTTIME_MACROS_SVH
`define EXTTIME_MACROS_SVH

// sensor channels feeding the logger
`define TS_NUM_CHN   4

// bytes per serialized timestamp message, byte 0 first
`define TS_MSG_BYTES 8

// 16-bit words in one record
// byte 7 of the message is replaced by the channel number
`define TS_BUF_WORDS 4

`endif

/* common/exttime_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// external timestamp logger types
// byte, word and channel index types, FSM state encodings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package exttime_pkg;

    typedef logic [7:0]  ts_byte_t;     // one serialized message byte
    typedef logic [15:0] ts_word_t;     // one record word, host side
    typedef logic [1:0]  chn_idx_t;     // sensor channel number

    // per-channel capture FIFO
    typedef enum logic [1:0] {
        FF_EMPTY = 2'd0,                // waiting for strobe
        FF_FILL  = 2'd1,                // capturing bytes 0..7
        FF_FULL  = 2'd2,                // message held, not yet read
        FF_READ  = 2'd3                 // replay in progress
    } fifo_state_e;

    // shared copy path
    typedef enum logic [1:0] {
        CP_IDLE  = 2'd0,                // free for a grant
        CP_COPY  = 2'd1,                // reading granted FIFO
        CP_HOLD  = 2'd2                 // record waits for host readout
    } copy_state_e;

endpackage

`default_nettype wire

/* common/ts_chan_if.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timestamp channel interface
// links one capture FIFO to the arbiter and the copy engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

interface ts_chan_if;
    import exttime_pkg::*;

    logic     full;                     // message captured and held
    ts_byte_t dout;                     // replay byte, one cycle after rd
    logic     rd;                       // advance replay pointer
    logic     rel;                      // release pulse, clears full

    modport fifo (
        output full,
        output dout,
        input  rd,
        input  rel
    );

    modport copier (
        input  dout,
        output rd,
        output rel
    );

    modport monitor (
        input  full                     // arbiter only looks at full
    );

endinterface

`default_nettype wire

/* source/timestamp_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timestamp capture FIFO
// captures one 8-byte message after its strobe and replays it on rd
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "exttime_macros.svh"

module timestamp_fifo (
    input  wire logic                 mclk,
    input  wire logic                 rst_n,
    input  wire logic                 en,     // channel enable, low empties FIFO
    input  wire logic                 stb,    // one cycle before byte 0
    input  wire exttime_pkg::ts_byte_t din,   // serialized message byte
    ts_chan_if.fifo                   chn
);
    import exttime_pkg::*;

    localparam int unsigned PTR_W = $clog2(`TS_MSG_BYTES);

    fifo_state_e      state;
    logic [PTR_W-1:0] wcnt;                   // capture byte counter
    logic [PTR_W-1:0] rptr;                   // replay pointer
    ts_byte_t         mem [`TS_MSG_BYTES];    // message storage
    ts_byte_t         dout_r;
    logic             rd_ok;

    assign rd_ok    = chn.rd && chn.full;     // rd only counts with a message
    assign chn.full = (state == FF_FULL) || (state == FF_READ);
    assign chn.dout = dout_r;

    always_ff @(posedge mclk) begin
        if (!rst_n || !en) begin
            state <= FF_EMPTY;
            wcnt  <= '0;
            rptr  <= '0;
        end else begin
            case (state)
                FF_EMPTY: if (stb) begin              // strobes elsewhere are dropped
                    state <= FF_FILL;
                    wcnt  <= '0;
                    rptr  <= '0;
                end
                FF_FILL: begin
                    wcnt <= wcnt + 1'b1;
                    if (wcnt == PTR_W'(`TS_MSG_BYTES - 1))
                        state <= FF_FULL;              // full from next cycle
                end
                FF_FULL: begin
                    if (chn.rel)    state <= FF_EMPTY;
                    else if (rd_ok) begin
                        state <= FF_READ;
                        rptr  <= rptr + 1'b1;
                    end
                end
                FF_READ: begin
                    if (chn.rel)    state <= FF_EMPTY;
                    else if (rd_ok) rptr  <= rptr + 1'b1;
                end
                default: state <= FF_EMPTY;
            endcase
        end
    end

    // payload path
    always_ff @(posedge mclk) begin
        if (state == FF_FILL) mem[wcnt] <= din;      // byte wcnt on din now
        if (rd_ok)            dout_r    <= mem[rptr]; // byte out one cycle later
    end

endmodule

`default_nettype wire

/* ext_logger/ts_arbiter.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// copy path arbiter
// fixed priority, lowest-numbered full channel wins the copy engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "exttime_macros.svh"

module ts_arbiter (
    input  wire logic                  mclk,
    input  wire logic                  rst_n,
    ts_chan_if.monitor                 chn0,
    ts_chan_if.monitor                 chn1,
    ts_chan_if.monitor                 chn2,
    ts_chan_if.monitor                 chn3,
    input  wire logic                  idle,       // copy engine free
    output      logic                  grant_vld,
    output      exttime_pkg::chn_idx_t grant_chn
);
    import exttime_pkg::*;

    logic [`TS_NUM_CHN-1:0] full_w;
    logic                   any_full;
    chn_idx_t               win_chn;               // encoder result

    assign full_w   = {chn3.full, chn2.full, chn1.full, chn0.full};
    assign any_full = |full_w;

    // scan downwards so the lowest full index is the last one kept
    always_comb begin
        win_chn = '0;
        for (int i = `TS_NUM_CHN - 1; i >= 0; i--) begin
            if (full_w[i]) win_chn = chn_idx_t'(i);
        end
    end

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            grant_vld <= 1'b0;
            grant_chn <= '0;
        end else if (!grant_vld) begin
            if (idle && any_full) begin            // new grant only to idle engine
                grant_vld <= 1'b1;
                grant_chn <= win_chn;              // frozen for this copy
            end
        end else if (!idle) begin
            grant_vld <= 1'b0;                     // engine took it
        end
    end

endmodule

`default_nettype wire

/* ext_logger/ts_copy_engine.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timestamp copy engine
// moves the granted message into the 4 x 16 record buffer, puts the
// channel number over byte 7 and pulses the timestamp request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "exttime_macros.svh"

module ts_copy_engine (
    input  wire logic                  mclk,
    input  wire logic                  rst_n,
    input  wire logic                  grant_vld,
    input  wire exttime_pkg::chn_idx_t grant_chn,
    output      logic                  idle,
    output      logic                  ts_req,    // one cycle, with the grant
    ts_chan_if.copier                  chn0,
    ts_chan_if.copier                  chn1,
    ts_chan_if.copier                  chn2,
    ts_chan_if.copier                  chn3,
    input  wire logic [1:0]            raddr,     // host word address
    output      exttime_pkg::ts_word_t rec_word,
    output      logic                  rec_rdy,
    input  wire logic                  rec_free   // last word read
);
    import exttime_pkg::*;

    localparam int unsigned CNT_W = $clog2(`TS_MSG_BYTES) + 1;

    copy_state_e      state;
    logic [CNT_W-1:0] cnt;                        // 0..7 read, 8 last byte
    chn_idx_t         sel_chn;                    // latched winner
    logic             rd_act;
    logic             rel_act;
    logic             wr_en;
    logic [1:0]       wr_idx;
    ts_byte_t         dout_w [`TS_NUM_CHN];
    ts_byte_t         cur_byte;
    ts_byte_t         prev_byte;                  // low byte of the pair
    ts_word_t         rec_buf [`TS_BUF_WORDS];

    assign dout_w[0] = chn0.dout;
    assign dout_w[1] = chn1.dout;
    assign dout_w[2] = chn2.dout;
    assign dout_w[3] = chn3.dout;
    assign cur_byte  = dout_w[sel_chn];           // 4:1 mux

    assign idle    = (state == CP_IDLE);
    assign ts_req  = idle && grant_vld;
    assign rec_rdy = (state == CP_HOLD);
    assign rd_act  = (state == CP_COPY) && (cnt < CNT_W'(`TS_MSG_BYTES));
    assign rel_act = (state == CP_COPY) && (cnt == CNT_W'(`TS_MSG_BYTES));

    assign chn0.rd  = rd_act  && (sel_chn == 2'd0);
    assign chn1.rd  = rd_act  && (sel_chn == 2'd1);
    assign chn2.rd  = rd_act  && (sel_chn == 2'd2);
    assign chn3.rd  = rd_act  && (sel_chn == 2'd3);
    assign chn0.rel = rel_act && (sel_chn == 2'd0);
    assign chn1.rel = rel_act && (sel_chn == 2'd1);
    assign chn2.rel = rel_act && (sel_chn == 2'd2);
    assign chn3.rel = rel_act && (sel_chn == 2'd3);

    // byte cnt-1 is on dout, odd bytes close a word
    assign wr_en  = (state == CP_COPY) && (cnt != '0) && !cnt[0];
    assign wr_idx = cnt[2:1] - 2'd1;              // cnt 8 wraps to word 3

    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            state   <= CP_IDLE;
            cnt     <= '0;
            sel_chn <= '0;
        end else begin
            case (state)
                CP_IDLE: if (grant_vld) begin
                    state   <= CP_COPY;
                    cnt     <= '0;
                    sel_chn <= grant_chn;
                end
                CP_COPY: begin
                    cnt <= cnt + 1'b1;
                    if (rel_act) state <= CP_HOLD;  // record complete
                end
                CP_HOLD: if (rec_free) state <= CP_IDLE;
                default: state <= CP_IDLE;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        prev_byte <= cur_byte;
        if (wr_en) begin
            if (rel_act) rec_buf[wr_idx] <= {6'b0, sel_chn, prev_byte}; // byte 7 dropped
            else         rec_buf[wr_idx] <= {cur_byte, prev_byte};
        end
    end

    assign rec_word = rec_buf[raddr];

endmodule

`default_nettype wire

/* ext_logger/ts_readout.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host readout port
// ready flag, word address and buffer release for the record buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "exttime_macros.svh"

module ts_readout (
    input  wire logic                  mclk,
    input  wire logic                  rst_n,
    input  wire logic                  rd_stb,    // host read strobe
    input  wire logic                  rec_rdy,   // record complete
    input  wire exttime_pkg::ts_word_t rec_word,
    output      logic [1:0]            raddr,
    output      logic                  rdy,
    output      exttime_pkg::ts_word_t rdata,
    output      logic                  rec_free   // pulse on fourth read
);

    logic rd_acc;                                 // accepted read
    logic last_word;

    assign rdy       = rec_rdy;                   // no extra latency to host
    assign rdata     = rec_word;                  // word at raddr, same cycle
    assign rd_acc    = rd_stb && rdy;             // strobes without rdy ignored
    assign last_word = (raddr == 2'(`TS_BUF_WORDS - 1));
    assign rec_free  = rd_acc && last_word;

    // raddr wraps back to word 0 with the release
    always_ff @(posedge mclk) begin
        if (!rst_n) begin
            raddr <= '0;
        end else if (rd_acc) begin
            if (last_word) raddr <= '0;
            else           raddr <= raddr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/ext_timestamp_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// external timestamp logger top
// four capture FIFOs share one copy engine through a priority arbiter,
// host reads the 4 x 16 record through the readout port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "exttime_macros.svh"

module ext_timestamp_top (
    input  wire logic                   mclk,
    input  wire logic                   rst_n,
    input  wire logic [`TS_NUM_CHN-1:0] en_chn,       // per-channel enable
    input  wire logic [`TS_NUM_CHN-1:0] ts_stb,       // message strobes
    input  wire exttime_pkg::ts_byte_t  ts_data_chn0,
    input  wire exttime_pkg::ts_byte_t  ts_data_chn1,
    input  wire exttime_pkg::ts_byte_t  ts_data_chn2,
    input  wire exttime_pkg::ts_byte_t  ts_data_chn3,
    input  wire logic                   rd_stb,
    output      logic                   ts_req,       // timestamp request
    output      logic                   rdy,
    output      exttime_pkg::ts_word_t  rdata
);
    import exttime_pkg::*;

    logic       idle;
    logic       grant_vld;
    chn_idx_t   grant_chn;
    logic [1:0] raddr;
    ts_word_t   rec_word;
    logic       rec_rdy;
    logic       rec_free;

    ts_chan_if chn0_if ();
    ts_chan_if chn1_if ();
    ts_chan_if chn2_if ();
    ts_chan_if chn3_if ();

    timestamp_fifo fifo0_i (.mclk(mclk), .rst_n(rst_n), .en(en_chn[0]), .stb(ts_stb[0]),
                            .din(ts_data_chn0), .chn(chn0_if.fifo));
    timestamp_fifo fifo1_i (.mclk(mclk), .rst_n(rst_n), .en(en_chn[1]), .stb(ts_stb[1]),
                            .din(ts_data_chn1), .chn(chn1_if.fifo));
    timestamp_fifo fifo2_i (.mclk(mclk), .rst_n(rst_n), .en(en_chn[2]), .stb(ts_stb[2]),
                            .din(ts_data_chn2), .chn(chn2_if.fifo));
    timestamp_fifo fifo3_i (.mclk(mclk), .rst_n(rst_n), .en(en_chn[3]), .stb(ts_stb[3]),
                            .din(ts_data_chn3), .chn(chn3_if.fifo));

    ts_arbiter arbiter_i (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .chn0      (chn0_if.monitor),
        .chn1      (chn1_if.monitor),
        .chn2      (chn2_if.monitor),
        .chn3      (chn3_if.monitor),
        .idle      (idle),
        .grant_vld (grant_vld),
        .grant_chn (grant_chn)
    );

    ts_copy_engine copy_i (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .grant_vld (grant_vld),
        .grant_chn (grant_chn),
        .idle      (idle),
        .ts_req    (ts_req),
        .chn0      (chn0_if.copier),
        .chn1      (chn1_if.copier),
        .chn2      (chn2_if.copier),
        .chn3      (chn3_if.copier),
        .raddr     (raddr),
        .rec_word  (rec_word),
        .rec_rdy   (rec_rdy),
        .rec_free  (rec_free)
    );

    ts_readout readout_i (
        .mclk      (mclk),
        .rst_n     (rst_n),
        .rd_stb    (rd_stb),
        .rec_rdy   (rec_rdy),
        .rec_word  (rec_word),
        .raddr     (raddr),
        .rdy       (rdy),
        .rdata     (rdata),
        .rec_free  (rec_free)
    );

endmodule

`default_nettype wire

/* sim/ext_timestamp_properties.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timestamp logger protocol checks
// request pulse, ready flag and idle rules at the top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module ext_timestamp_properties (
    input wire logic       mclk,
    input wire logic       rst_n,
    input wire logic [3:0] ts_stb,
    input wire logic       rd_stb,
    input wire logic       ts_req,
    input wire logic       rdy
);

    logic seen_stb;                             // any strobe since reset

    always_ff @(posedge mclk) begin
        if (!rst_n)       seen_stb <= 1'b0;
        else if (|ts_stb) seen_stb <= 1'b1;
    end

    // one-cycle request
    req_one_cycle: assert property (@(posedge mclk) disable iff (!rst_n)
        ts_req |=> !ts_req) else $error("ts_req longer than one cycle");

    // rdy only drops after an accepted read
    rdy_fall_on_read: assert property (@(posedge mclk) disable iff (!rst_n)
        $fell(rdy) |-> $past(rd_stb)) else $error("rdy fell without a read");

    req_not_while_rdy: assert property (@(posedge mclk) disable iff (!rst_n)
        ts_req |-> !rdy) else $error("ts_req while record unread");

    quiet_until_stb: assert property (@(posedge mclk) disable iff (!rst_n)
        !seen_stb |-> (!ts_req && !rdy)) else $error("activity before first strobe");

endmodule

bind ext_timestamp_top ext_timestamp_properties props_i (
    .mclk(mclk), .rst_n(rst_n), .ts_stb(ts_stb), .rd_stb(rd_stb),
    .ts_req(ts_req), .rdy(rdy)
);

`default_nettype wire

/* sim/tb_ext_timestamp.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// external timestamp logger testbench
// LFSR messages on the four channels, priority model of the record
// order, record readout checked against the message format
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none
`include "exttime_macros.svh"

module tb_ext_timestamp;

    logic        mclk;
    logic        rst_n;
    logic [3:0]  en_chn;
    logic [3:0]  ts_stb;
    logic [7:0]  data [4];                      // per-channel message byte
    logic        rd_stb;
    logic        ts_req;
    logic        rdy;
    logic [15:0] rdata;
    logic [31:0] lfsr = 32'h22a7;
    int          cyc = 0;                       // cycles since start
    int          req_cnt = 0;                   // ts_req pulses seen
    int          exp_req = 0;                   // pulses the model expects
    logic        strobed = 1'b0;
    logic [3:0]  pending = 4'b0;                // model: channels holding a message
    logic [7:0]  msg [4][`TS_MSG_BYTES];        // model: held bytes

    ext_timestamp_top dut_i (
        .mclk(mclk), .rst_n(rst_n), .en_chn(en_chn), .ts_stb(ts_stb),
        .ts_data_chn0(data[0]), .ts_data_chn1(data[1]),
        .ts_data_chn2(data[2]), .ts_data_chn3(data[3]),
        .rd_stb(rd_stb), .ts_req(ts_req), .rdy(rdy), .rdata(rdata)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) b = {b[6:0], lfsr_step()};
        return b;
    endfunction

    task automatic report_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s expected %0h actual %0h", name, exp, act);
        $display("ERRORS FOUND");
        $fatal(1, "check failed");
    endtask

    task automatic step();
        @(posedge mclk);
        #0.5;
    endtask

    always @(posedge mclk) begin
        cyc <= cyc + 1;
        if (cyc >= 2000) begin
            $display("timeout: run exceeded 2000 cycles");
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    always @(negedge mclk) if (rst_n && ts_req) req_cnt <= req_cnt + 1;

    // nothing may happen before the first strobe
    assert property (@(posedge mclk) disable iff (!rst_n) !strobed |-> (!ts_req && !rdy))
        else report_fail("idle_after_reset", 0, {ts_req, rdy});

    // strobe the channels in mask, then eight bytes each
    task automatic send_msgs(input logic [3:0] mask);
        logic [3:0] acc;
        acc     = mask & en_chn & ~pending;
        strobed = 1'b1;
        ts_stb  = mask;
        step();
        ts_stb  = '0;
        for (int i = 0; i < `TS_MSG_BYTES; i++) begin
            for (int c = 0; c < 4; c++) if (mask[c]) begin
                data[c] = lfsr_byte();
                if (acc[c]) msg[c][i] = data[c];
            end
            step();
        end
        for (int c = 0; c < 4; c++) data[c] = '0;
        pending = pending | acc;
    endtask

    // lowest pending channel is the next record, one request per record
    task automatic read_record(input string name);
        int          c;
        logic [15:0] exp;
        c = 0;
        while (!pending[c]) c++;
        while (!rdy) step();
        exp_req = exp_req + 1;
        assert (req_cnt == exp_req) else report_fail({name, "_req"}, exp_req, req_cnt);
        for (int k = 0; k < `TS_BUF_WORDS; k++) begin
            if (k < 3) exp = {msg[c][2*k+1], msg[c][2*k]};
            else       exp = {6'b0, 2'(c), msg[c][6]};
            assert (rdy) else report_fail({name, "_rdy"}, 1, rdy);
            assert (rdata == exp) else report_fail(name, exp, rdata);
            rd_stb = 1'b1;
            step();
        end
        rd_stb     = 1'b0;
        pending[c] = 1'b0;
        assert (!rdy) else report_fail({name, "_rdy_drop"}, 0, rdy);
    endtask

    task automatic check_quiet(input string name, input int n);
        repeat (n) step();
        assert (req_cnt == exp_req) else report_fail({name, "_req"}, exp_req, req_cnt);
        assert (!rdy) else report_fail({name, "_rdy"}, 0, rdy);
    endtask

    initial begin
        int t0;
        rst_n  = 1'b0;
        en_chn = 4'hf;
        ts_stb = '0;
        rd_stb = 1'b0;
        for (int c = 0; c < 4; c++) data[c] = '0;
        repeat (16) @(posedge mclk);
        #0.5 rst_n = 1'b1;
        repeat (10) step();                     // quiet after reset

        t0 = cyc;                               // single message, channel 2
        send_msgs(4'b0100);
        while (!rdy) step();
        assert (cyc - t0 == 20) else report_fail("rdy_latency", 20, cyc - t0);
        read_record("chn2_record");

        send_msgs(4'b1010);                     // same-cycle strobes, 1 before 3
        read_record("prio_first");
        read_record("prio_second");

        send_msgs(4'b0001);                     // record waits, later message held
        while (!rdy) step();
        send_msgs(4'b0010);
        send_msgs(4'b0010);                     // channel still full, dropped
        read_record("held_chn0");
        read_record("held_chn1");
        check_quiet("no_duplicate", 30);

        en_chn = 4'b1011;                       // disabled channel
        send_msgs(4'b0100);
        check_quiet("disabled_chn", 30);
        en_chn = 4'hf;
        send_msgs(4'b0001);
        while (!rdy) step();
        send_msgs(4'b1000);
        step();
        en_chn     = 4'b0111;                   // discard full channel 3
        pending[3] = 1'b0;
        step();
        en_chn     = 4'hf;
        read_record("discard_chn0");
        check_quiet("discarded", 30);

        rd_stb = 1'b1;                          // strobes without rdy
        repeat (10) step();
        rd_stb = 1'b0;
        send_msgs(4'b0010);
        read_record("early_rd_stb");

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/exttime_pkg.sv
common/ts_chan_if.sv
source/timestamp_fifo.sv
ext_logger/ts_arbiter.sv
ext_logger/ts_copy_engine.sv
ext_logger/ts_readout.sv
source/ext_timestamp_top.sv
sim/ext_timestamp_properties.sv
sim/tb_ext_timestamp.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the timestamp logger testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ext_timestamp -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ext_timestamp)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$out" | grep -q "^NO ERRORS$"; then
    exit 0
fi
echo "pass message not found"
exit 1
